/* lockin_top.f */
+incdir+dv
design/lockin_pkg.sv
design/phase_dds.sv
design/source_select.sv
design/lockin_demod.sv
design/stage_fifo.sv
design/capture_memory.sv
design/lockin_top.sv
dv/lockin_tb.sv

/* Makefile */
TOP = lockin_tb

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f lockin_top.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* dv/lockin_tests.svh */
////////////////////
// Readback
////////////////////

// Walks the capture RAM and matches sample words and X/Y pairs against the model queues
task automatic check_capture(input int n_words);
	lockin_pkg::cap_word_t got;
	lockin_pkg::cap_word_t exp;
	lockin_pkg::cap_word_t words[$];
	lockin_pkg::result_t r;
	int i;
	for (i = 0; i < n_words; i++)
	begin
		read_word(i, got);
		words.push_back(got);
	end
	i = 0;
	while (i < words.size())
	begin
		if (words[i].tag == lockin_pkg::TAG_SAMPLE && exp_samples.size() > 0)
		begin
			exp.tag = lockin_pkg::TAG_SAMPLE;
			exp.data = widen_sample(exp_samples.pop_front());
			check_word(words[i], exp, $sformatf("sample word at %0d", i));
			i++;
		end
		else if (words[i].tag == lockin_pkg::TAG_X && exp_results.size() > 0 &&
			i + 1 < words.size())
		begin
			// Y must follow its X directly
			r = exp_results.pop_front();
			exp.tag = lockin_pkg::TAG_X;
			exp.data = r.x;
			check_word(words[i], exp, $sformatf("X word at %0d", i));
			exp.tag = lockin_pkg::TAG_Y;
			exp.data = r.y;
			check_word(words[i+1], exp, $sformatf("Y word at %0d", i + 1));
			i += 2;
		end
		else
		begin
			$display("Word at address %0d has tag %0d where no such word was expected",
				i, int'(words[i].tag));
			other_errors++;
			i++;
		end
	end
	if (exp_samples.size() != 0 || exp_results.size() != 0)
	begin
		$display("%0d samples and %0d results never reached the capture memory",
			exp_samples.size(), exp_results.size());
		other_errors++;
	end
endtask

////////////////////
// Directed tests
////////////////////

task automatic reset_state_check();
	cfg = '0;
	cfg.n_avg = 16'd1;
	apply_reset();
	check_count(word_count, count_t'(0), "word count after reset");
	check_flag(overflow, 1'b0, "overflow after reset");
	check_flag(result_done, 1'b0, "result_done after reset");
endtask

// Samples of one channel only with no result completing
task automatic raw_adc_capture();
	int ch;
	int i;
	for (ch = 0; ch < 2; ch++)
	begin
		cfg.source = (ch == 0) ? lockin_pkg::SRC_ADC_A : lockin_pkg::SRC_ADC_B;
		cfg.phase_inc = 32'h0100_0000;
		cfg.n_avg = 16'd100;
		cfg.capture_samples = 1'b1;
		apply_reset();
		for (i = 0; i < 10; i++)
			strobe_sample(next_random_sample(), next_random_sample());
		wait_words(10);
		check_count(word_count, count_t'(10), $sformatf("raw capture on channel %0d", ch));
		check_flag(overflow, 1'b0, $sformatf("overflow on channel %0d", ch));
		check_capture(10);
	end
endtask

task automatic sim_source_demod();
	int i;
	cfg.source = lockin_pkg::SRC_SIM;
	cfg.phase_inc = 32'h0533_3333;
	cfg.n_avg = 16'd16;
	cfg.capture_samples = 1'b0;
	apply_reset();
	for (i = 0; i < 32; i++)
		strobe_sample(next_random_sample(), next_random_sample());
	wait_words(4);
	check_count(word_count, count_t'(4), "two results from the simulated source");
	check_count(count_t'(done_pulses), count_t'(2), "result_done pulses from the simulated source");
	check_flag(overflow, 1'b0, "overflow with the simulated source");
	check_capture(4);
endtask

// 32 samples plus 8 X/Y pairs share the RAM
task automatic adc_demod_with_capture();
	int i;
	cfg.source = lockin_pkg::SRC_ADC_B;
	cfg.phase_inc = 32'h0C80_0000;
	cfg.n_avg = 16'd4;
	cfg.capture_samples = 1'b1;
	apply_reset();
	for (i = 0; i < 32; i++)
		strobe_sample(next_random_sample(), next_random_sample());
	wait_words(48);
	check_count(word_count, count_t'(48), "samples and results together");
	check_count(count_t'(done_pulses), count_t'(8), "result_done pulses with raw capture");
	check_flag(overflow, 1'b0, "overflow with raw capture and results");
	check_capture(48);
endtask

task automatic full_memory_overflow();
	int i;
	cfg.source = lockin_pkg::SRC_ADC_A;
	cfg.phase_inc = 32'h0200_0000;
	cfg.n_avg = 16'd1000;
	cfg.capture_samples = 1'b1;
	apply_reset();
	for (i = 0; i < 80; i++)
		strobe_sample(next_random_sample(), next_random_sample());
	wait_words(lockin_pkg::CAP_DEPTH);
	check_count(word_count, count_t'(lockin_pkg::CAP_DEPTH), "word count at full memory");
	check_flag(overflow, 1'b1, "overflow at full memory");
	for (i = 0; i < 4; i++)
		strobe_sample(next_random_sample(), next_random_sample());
	repeat (8) @(negedge clk_custom);
	check_count(word_count, count_t'(lockin_pkg::CAP_DEPTH), "word count after more strobes");
	check_flag(overflow, 1'b1, "overflow stays set");
	// Only the first samples fit
	while (exp_samples.size() > lockin_pkg::CAP_DEPTH)
		void'(exp_samples.pop_back());
	check_capture(lockin_pkg::CAP_DEPTH);
endtask

/* dv/lockin_tb.sv */
`timescale 1ns/1ps

module lockin_tb;

	typedef logic [lockin_pkg::CAP_AW:0] count_t;
	typedef logic [lockin_pkg::LUT_BITS-1:0] lut_idx_t;

	// Strobes over all tests at two 20 ns cycles each
	localparam int TOTAL_STROBES = 168;
	localparam int WATCHDOG_NS = TOTAL_STROBES * 40 + 40000;
	localparam int WAIT_LIMIT = 200;

	logic clk_custom;
	logic rst_n;
	lockin_pkg::cfg_t cfg;
	lockin_pkg::sample_t adc_a;
	lockin_pkg::sample_t adc_b;
	logic sample_strobe;
	logic [lockin_pkg::CAP_AW-1:0] rd_addr;
	lockin_pkg::cap_word_t rd_data;
	count_t word_count;
	logic overflow;
	logic result_done;

	int mismatch_errors;
	int other_errors;
	logic [31:0] lcg_state;
	int done_pulses;

	// Reference model state
	logic [lockin_pkg::PHASE_W-1:0] model_phase;
	logic signed [lockin_pkg::ACC_W-1:0] model_x;
	logic signed [lockin_pkg::ACC_W-1:0] model_y;
	int model_count;
	lockin_pkg::sample_t exp_samples[$];
	lockin_pkg::result_t exp_results[$];

	lockin_top i_lockin_top (
		.clk_custom(clk_custom),
		.rst_n(rst_n),
		.cfg(cfg),
		.adc_a(adc_a),
		.adc_b(adc_b),
		.sample_strobe(sample_strobe),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.word_count(word_count),
		.overflow(overflow),
		.result_done(result_done)
	);

	always #10 clk_custom = ~clk_custom;

	// Counts result_done pulses since the last reset
	always @(posedge clk_custom)
	begin
		if (!rst_n)
			done_pulses <= 0;
		else if (result_done === 1'b1)
			done_pulses <= done_pulses + 1;
	end

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_word(input lockin_pkg::cap_word_t got, input lockin_pkg::cap_word_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("Mismatch at %0d ns: %s got tag %0d data %0d, expected tag %0d data %0d",
				$time, what, got.tag, got.data, exp.tag, exp.data);
			mismatch_errors++;
		end
	endtask

	task automatic check_count(input count_t got, input count_t exp, input string what);
		if (got !== exp)
		begin
			$display("Mismatch at %0d ns: %s got %0d, expected %0d", $time, what, got, exp);
			mismatch_errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("Mismatch at %0d ns: %s got %b, expected %b", $time, what, got, exp);
			mismatch_errors++;
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////

	function automatic lockin_pkg::sample_t next_random_sample();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[29:16];
	endfunction

	function automatic logic signed [lockin_pkg::ACC_W-1:0] widen_sample(
		input lockin_pkg::sample_t s);
		return {{(lockin_pkg::ACC_W - lockin_pkg::ADC_W){s[lockin_pkg::ADC_W-1]}}, s};
	endfunction

	// Reference sine brought down to the ADC range
	function automatic lockin_pkg::sample_t sim_sample(input logic signed [lockin_pkg::REF_W-1:0] s);
		logic signed [lockin_pkg::REF_W-1:0] shifted;
		shifted = s >>> (lockin_pkg::REF_W - lockin_pkg::ADC_W);
		return shifted[lockin_pkg::ADC_W-1:0];
	endfunction

	task automatic apply_reset();
		rst_n = 1'b0;
		sample_strobe = 1'b0;
		model_phase = '0;
		model_x = '0;
		model_y = '0;
		model_count = 0;
		exp_samples.delete();
		exp_results.delete();
		repeat (2) @(negedge clk_custom);
		rst_n = 1'b1;
	endtask

	// Steps the model by one sample with the reference taken at the old phase
	task automatic model_step(input lockin_pkg::sample_t a, input lockin_pkg::sample_t b);
		lut_idx_t si;
		lut_idx_t ci;
		logic signed [lockin_pkg::REF_W-1:0] sine;
		logic signed [lockin_pkg::REF_W-1:0] cosine;
		lockin_pkg::sample_t s;
		logic signed [lockin_pkg::ACC_W-1:0] s64;
		lockin_pkg::result_t r;
		si = model_phase[lockin_pkg::PHASE_W-1 -: lockin_pkg::LUT_BITS];
		ci = si + lut_idx_t'(16);
		sine = lockin_pkg::SINE_TABLE[si];
		cosine = lockin_pkg::SINE_TABLE[ci];
		model_phase = model_phase + cfg.phase_inc;
		case (cfg.source)
			lockin_pkg::SRC_ADC_B: s = b;
			lockin_pkg::SRC_SIM: s = sim_sample(sine);
			default: s = a;
		endcase
		if (cfg.capture_samples)
			exp_samples.push_back(s);
		s64 = widen_sample(s);
		model_x = model_x + s64 * sine;
		model_y = model_y + s64 * cosine;
		model_count++;
		if (model_count == int'(cfg.n_avg))
		begin
			r.x = model_x;
			r.y = model_y;
			exp_results.push_back(r);
			model_x = '0;
			model_y = '0;
			model_count = 0;
		end
	endtask

	task automatic strobe_sample(input lockin_pkg::sample_t a, input lockin_pkg::sample_t b);
		adc_a = a;
		adc_b = b;
		sample_strobe = 1'b1;
		model_step(a, b);
		@(negedge clk_custom);
		sample_strobe = 1'b0;
		@(negedge clk_custom);
	endtask

	task automatic read_word(input int addr, output lockin_pkg::cap_word_t w);
		rd_addr = addr[lockin_pkg::CAP_AW-1:0];
		@(negedge clk_custom);
		w = rd_data;
	endtask

	// Waits on the word count since capture latency varies
	task automatic wait_words(input int target);
		int cycles;
		cycles = 0;
		while (int'(word_count) != target && cycles < WAIT_LIMIT)
		begin
			@(negedge clk_custom);
			cycles++;
		end
		if (int'(word_count) != target)
		begin
			$display("Capture stopped at %0d words while %0d were expected", word_count, target);
			other_errors++;
		end
		repeat (8) @(negedge clk_custom);
	endtask

`include "lockin_tests.svh"

	initial
	begin
		clk_custom = 1'b0;
		rst_n = 1'b0;
		cfg = '0;
		adc_a = '0;
		adc_b = '0;
		sample_strobe = 1'b0;
		rd_addr = '0;
		mismatch_errors = 0;
		other_errors = 0;
		lcg_state = 32'd3;
		reset_state_check();
		raw_adc_capture();
		sim_source_demod();
		adc_demod_with_capture();
		full_memory_overflow();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with the tests still running", WATCHDOG_NS);
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* design/lockin_top.sv */
`timescale 1ns/1ps

module lockin_top (
	input logic clk_custom,
	input logic rst_n,
	input lockin_pkg::cfg_t cfg,
	input lockin_pkg::sample_t adc_a,
	input lockin_pkg::sample_t adc_b,
	input logic sample_strobe,
	input logic [lockin_pkg::CAP_AW-1:0] rd_addr,
	output lockin_pkg::cap_word_t rd_data,
	output logic [lockin_pkg::CAP_AW:0] word_count,
	output logic overflow,
	output logic result_done
);

	lockin_pkg::ref_t ref_wave;
	logic ref_valid;
	lockin_pkg::sample_t sample;
	logic sample_valid;
	lockin_pkg::result_t result;
	logic result_valid;
	lockin_pkg::cap_word_t sample_word;
	logic sample_push;

	phase_dds i_phase_dds (
		.clk_custom(clk_custom),
		.rst_n(rst_n),
		.step(sample_strobe),
		.phase_inc(cfg.phase_inc),
		.ref_wave(ref_wave),
		.ref_valid(ref_valid)
	);

	source_select i_source_select (
		.clk_custom(clk_custom),
		.rst_n(rst_n),
		.strobe(sample_strobe),
		.source(cfg.source),
		.adc_a(adc_a),
		.adc_b(adc_b),
		.ref_sine(ref_wave.sine),
		.ref_valid(ref_valid),
		.sample(sample),
		.sample_valid(sample_valid)
	);

	lockin_demod i_lockin_demod (
		.clk_custom(clk_custom),
		.rst_n(rst_n),
		.sample(sample),
		.sample_valid(sample_valid),
		.ref_wave(ref_wave),
		.n_avg(cfg.n_avg),
		.result(result),
		.result_valid(result_valid)
	);

	// Raw samples are stored sign-extended
	assign sample_word.tag = lockin_pkg::TAG_SAMPLE;
	assign sample_word.data = lockin_pkg::ACC_W'(sample);
	assign sample_push = sample_valid && cfg.capture_samples;

	capture_memory i_capture_memory (
		.clk_custom(clk_custom),
		.rst_n(rst_n),
		.sample_word(sample_word),
		.sample_push(sample_push),
		.result(result),
		.result_push(result_valid),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.word_count(word_count),
		.overflow(overflow)
	);

	assign result_done = result_valid;

endmodule

/* design/capture_memory.sv */
`timescale 1ns/1ps

module capture_memory (
	input logic clk_custom,
	input logic rst_n,
	input lockin_pkg::cap_word_t sample_word,
	input logic sample_push,
	input lockin_pkg::result_t result,
	input logic result_push,
	input logic [lockin_pkg::CAP_AW-1:0] rd_addr,
	output lockin_pkg::cap_word_t rd_data,
	output logic [lockin_pkg::CAP_AW:0] word_count,
	output logic overflow
);

	lockin_pkg::cap_word_t samp_head;
	lockin_pkg::result_t res_head;
	logic samp_req;
	logic res_req;
	logic samp_drop;
	logic res_drop;

	logic samp_ok;
	logic res_ok;
	logic grant_s;
	logic grant_r;
	logic prio_r;
	logic busy_y;
	logic signed [lockin_pkg::ACC_W-1:0] y_hold;

	lockin_pkg::cap_word_t mem [lockin_pkg::CAP_DEPTH];
	lockin_pkg::cap_word_t wr_word;
	logic wr_en;

	stage_fifo #(
		.payload_t(lockin_pkg::cap_word_t)
	) i_sample_fifo (
		.clk_custom(clk_custom),
		.rst_n(rst_n),
		.push(sample_push),
		.push_data(sample_word),
		.pop(grant_s),
		.pop_data(samp_head),
		.not_empty(samp_req),
		.dropped(samp_drop)
	);

	stage_fifo #(
		.payload_t(lockin_pkg::result_t)
	) i_result_fifo (
		.clk_custom(clk_custom),
		.rst_n(rst_n),
		.push(result_push),
		.push_data(result),
		.pop(grant_r),
		.pop_data(res_head),
		.not_empty(res_req),
		.dropped(res_drop)
	);

	////////////////////
	// Round-robin arbiter
	////////////////////

	// No grants once the RAM is full; a pair needs room for both words
	assign samp_ok = samp_req && (word_count != lockin_pkg::CAP_FULL);
	assign res_ok = res_req && (word_count < lockin_pkg::CAP_PAIR_LIMIT);

	assign grant_s = !busy_y && samp_ok && (!res_ok || !prio_r);
	assign grant_r = !busy_y && res_ok && (!samp_ok || prio_r);

	assign wr_en = grant_s || grant_r || busy_y;

	always_comb
	begin
		wr_word = samp_head;
		if (busy_y)
		begin
			wr_word.tag = lockin_pkg::TAG_Y;
			wr_word.data = y_hold;
		end
		else if (grant_r)
		begin
			wr_word.tag = lockin_pkg::TAG_X;
			wr_word.data = res_head.x;
		end
	end

	always_ff @(posedge clk_custom)
	begin
		if (!rst_n)
		begin
			prio_r <= 1'b0;
			busy_y <= 1'b0;
			word_count <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (grant_s)
				prio_r <= 1'b1;
			else if (grant_r)
				prio_r <= 1'b0;
			// Second cycle of a result grant writes Y
			busy_y <= grant_r;
			if (wr_en)
				word_count <= word_count + 1'b1;
			overflow <= overflow || samp_drop || res_drop;
		end
	end

	////////////////////
	// Capture RAM
	////////////////////

	always_ff @(posedge clk_custom)
	begin
		if (grant_r)
			y_hold <= res_head.y;
		if (wr_en)
			mem[word_count[lockin_pkg::CAP_AW-1:0]] <= wr_word;
		rd_data <= mem[rd_addr];
	end

endmodule

/* design/stage_fifo.sv */
`timescale 1ns/1ps

module stage_fifo #(
	parameter type payload_t = logic
) (
	input logic clk_custom,
	input logic rst_n,
	input logic push,
	input payload_t push_data,
	input logic pop,
	output payload_t pop_data,
	output logic not_empty,
	output logic dropped
);

	payload_t mem [lockin_pkg::FIFO_DEPTH];

	// One extra pointer bit tells full from empty
	logic [lockin_pkg::FIFO_PW:0] wr_ptr;
	logic [lockin_pkg::FIFO_PW:0] rd_ptr;
	logic full;

	assign not_empty = (wr_ptr != rd_ptr);
	assign full = (wr_ptr[lockin_pkg::FIFO_PW] != rd_ptr[lockin_pkg::FIFO_PW]) &&
		(wr_ptr[lockin_pkg::FIFO_PW-1:0] == rd_ptr[lockin_pkg::FIFO_PW-1:0]);

	assign dropped = push && full;

	// Head word is visible before the pop
	assign pop_data = mem[rd_ptr[lockin_pkg::FIFO_PW-1:0]];

	always_ff @(posedge clk_custom)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && not_empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk_custom)
	begin
		if (push && !full)
			mem[wr_ptr[lockin_pkg::FIFO_PW-1:0]] <= push_data;
	end

endmodule

/* design/lockin_demod.sv */
`timescale 1ns/1ps

module lockin_demod (
	input logic clk_custom,
	input logic rst_n,
	input lockin_pkg::sample_t sample,
	input logic sample_valid,
	input lockin_pkg::ref_t ref_wave,
	input logic [lockin_pkg::NAVG_W-1:0] n_avg,
	output lockin_pkg::result_t result,
	output logic result_valid
);

	logic signed [lockin_pkg::PROD_W-1:0] prod_s;
	logic signed [lockin_pkg::PROD_W-1:0] prod_c;
	logic prod_valid;

	lockin_pkg::result_t acc;
	lockin_pkg::result_t sum;
	logic [lockin_pkg::NAVG_W-1:0] count;
	logic last;

	////////////////////
	// Product stage
	////////////////////

	always_ff @(posedge clk_custom)
	begin
		if (!rst_n)
			prod_valid <= 1'b0;
		else
			prod_valid <= sample_valid;
	end

	always_ff @(posedge clk_custom)
	begin
		if (sample_valid)
		begin
			prod_s <= sample * ref_wave.sine;
			prod_c <= sample * ref_wave.cosine;
		end
	end

	////////////////////
	// Accumulation stage
	////////////////////

	assign sum.x = acc.x + lockin_pkg::ACC_W'(prod_s);
	assign sum.y = acc.y + lockin_pkg::ACC_W'(prod_c);
	assign last = (count == n_avg - 1'b1);

	always_ff @(posedge clk_custom)
	begin
		if (!rst_n)
		begin
			acc <= '0;
			count <= '0;
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= prod_valid && last;
			if (prod_valid)
			begin
				// Restart from zero so the next run can start at once
				if (last)
				begin
					acc <= '0;
					count <= '0;
				end
				else
				begin
					acc <= sum;
					count <= count + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_custom)
	begin
		if (prod_valid && last)
			result <= sum;
	end

endmodule

/* design/source_select.sv */
`timescale 1ns/1ps

module source_select (
	input logic clk_custom,
	input logic rst_n,
	input logic strobe,
	input lockin_pkg::src_sel_t source,
	input lockin_pkg::sample_t adc_a,
	input lockin_pkg::sample_t adc_b,
	input logic signed [lockin_pkg::REF_W-1:0] ref_sine,
	input logic ref_valid,
	output lockin_pkg::sample_t sample,
	output logic sample_valid
);

	lockin_pkg::sample_t adc_q;
	logic strobe_q;
	logic signed [lockin_pkg::REF_W-1:0] sim_full;

	always_ff @(posedge clk_custom)
	begin
		if (!rst_n)
			strobe_q <= 1'b0;
		else
			strobe_q <= strobe;
	end

	always_ff @(posedge clk_custom)
	begin
		if (strobe)
			adc_q <= (source == lockin_pkg::SRC_ADC_B) ? adc_b : adc_a;
	end

	// Reference arrives one cycle after the strobe just like adc_q
	assign sim_full = ref_sine >>> lockin_pkg::SIM_SHIFT;

	assign sample = (source == lockin_pkg::SRC_SIM) ? sim_full[lockin_pkg::ADC_W-1:0] : adc_q;
	assign sample_valid = (source == lockin_pkg::SRC_SIM) ? ref_valid : strobe_q;

endmodule

/* design/phase_dds.sv */
`timescale 1ns/1ps

module phase_dds (
	input logic clk_custom,
	input logic rst_n,
	input logic step,
	input logic [lockin_pkg::PHASE_W-1:0] phase_inc,
	output lockin_pkg::ref_t ref_wave,
	output logic ref_valid
);

	logic [lockin_pkg::PHASE_W-1:0] phase;
	logic [lockin_pkg::LUT_BITS-1:0] sin_idx;
	logic [lockin_pkg::LUT_BITS-1:0] cos_idx;

	// Table index comes from the top of the accumulator
	assign sin_idx = phase[lockin_pkg::PHASE_W-1 -: lockin_pkg::LUT_BITS];
	assign cos_idx = sin_idx + lockin_pkg::LUT_QUARTER;

	always_ff @(posedge clk_custom)
	begin
		if (!rst_n)
		begin
			phase <= '0;
			ref_valid <= 1'b0;
		end
		else
		begin
			ref_valid <= step;
			if (step)
				phase <= phase + phase_inc;
		end
	end

	// Lookup uses the phase held before the step
	always_ff @(posedge clk_custom)
	begin
		if (step)
		begin
			ref_wave.sine <= lockin_pkg::SINE_TABLE[sin_idx];
			ref_wave.cosine <= lockin_pkg::SINE_TABLE[cos_idx];
		end
	end

endmodule

/* design/lockin_pkg.sv */
package lockin_pkg;

	////////////////////
	// Widths and depths
	////////////////////

	localparam int ADC_W = 14;
	localparam int REF_W = 16;
	localparam int PHASE_W = 32;
	localparam int LUT_BITS = 6;
	localparam int LUT_SIZE = 2 ** LUT_BITS;
	localparam int ACC_W = 64;
	localparam int NAVG_W = 16;
	localparam int PROD_W = ADC_W + REF_W;

	// Simulated input is the reference sine scaled down to ADC range
	localparam int SIM_SHIFT = REF_W - ADC_W;

	// Cosine is read a quarter period ahead of the sine
	localparam logic [LUT_BITS-1:0] LUT_QUARTER = LUT_BITS'(LUT_SIZE / 4);

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PW = $clog2(FIFO_DEPTH);
	localparam int CAP_DEPTH = 64;
	localparam int CAP_AW = 6;
	localparam logic [CAP_AW:0] CAP_FULL = (CAP_AW + 1)'(CAP_DEPTH);
	// An X/Y pair needs two free words
	localparam logic [CAP_AW:0] CAP_PAIR_LIMIT = (CAP_AW + 1)'(CAP_DEPTH - 1);

	////////////////////
	// Sine table
	////////////////////

	// round(32767 * sin(2*pi*k/64))
	localparam logic signed [REF_W-1:0] SINE_TABLE [LUT_SIZE] = '{
		0, 3212, 6393, 9512, 12539, 15446, 18204, 20787,
		23170, 25329, 27245, 28898, 30273, 31356, 32137, 32609,
		32767, 32609, 32137, 31356, 30273, 28898, 27245, 25329,
		23170, 20787, 18204, 15446, 12539, 9512, 6393, 3212,
		0, -3212, -6393, -9512, -12539, -15446, -18204, -20787,
		-23170, -25329, -27245, -28898, -30273, -31356, -32137, -32609,
		-32767, -32609, -32137, -31356, -30273, -28898, -27245, -25329,
		-23170, -20787, -18204, -15446, -12539, -9512, -6393, -3212
	};

	////////////////////
	// Types
	////////////////////

	typedef enum logic [1:0] {SRC_ADC_A, SRC_ADC_B, SRC_SIM} src_sel_t;

	typedef enum logic [1:0] {TAG_SAMPLE, TAG_X, TAG_Y} cap_tag_t;

	typedef struct packed {
		src_sel_t source;
		logic [PHASE_W-1:0] phase_inc;
		logic [NAVG_W-1:0] n_avg;
		logic capture_samples;
	} cfg_t;

	typedef struct packed {
		logic signed [REF_W-1:0] sine;
		logic signed [REF_W-1:0] cosine;
	} ref_t;

	typedef logic signed [ADC_W-1:0] sample_t;

	typedef struct packed {
		logic signed [ACC_W-1:0] x;
		logic signed [ACC_W-1:0] y;
	} result_t;

	typedef struct packed {
		cap_tag_t tag;
		logic signed [ACC_W-1:0] data;
	} cap_word_t;

endpackage
